/* design/cpu6502_params.svh */
//==================================================
// core widths and vector addresses; included by
// every RTL block that sizes a bus or picks a vector
//==================================================
`ifndef CPU6502_PARAMS_SVH
`define CPU6502_PARAMS_SVH

// data and address bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// low byte of each vector, high byte follows at +1
`define CPU_RESET_VEC 16'hFFFC
`define CPU_NMI_VEC   16'hFFFA
`define CPU_IRQ_VEC   16'hFFFE

`endif

/* design/cpuIsaPkg.sv */
//==================================================
// instruction set types: opcodes, ALU operations and
// status bit positions, used by decode and datapath
//==================================================
`default_nettype none

package cpuIsaPkg;

  // 6502 encodings of the supported subset
  typedef enum logic [7:0] {
    opLdaImm = 8'hA9,
    opLdxImm = 8'hA2,
    opAdcImm = 8'h69,
    opAndImm = 8'h29,
    opOraImm = 8'h09,
    opEorImm = 8'h49,
    opStaAbs = 8'h8D,
    opStxAbs = 8'h8E,
    opTax    = 8'hAA,
    opInx    = 8'hE8,
    opClc    = 8'h18,
    opSec    = 8'h38,
    opCli    = 8'h58,
    opSei    = 8'h78,
    opNop    = 8'hEA,
    opJmpAbs = 8'h4C
  } opcodeE;

  typedef enum logic [2:0] {
    aluAdc,
    aluAnd,
    aluOra,
    aluEor,
    aluPass,
    aluInc
  } aluOpE;

  // status byte layout as on the 6502
  localparam int unsigned flagC = 0;
  localparam int unsigned flagZ = 1;
  localparam int unsigned flagI = 2;
  localparam int unsigned flagV = 6;
  localparam int unsigned flagN = 7;

endpackage

`default_nettype wire

/* design/cpuCyclePkg.sv */
//==================================================
// bus cycle types: sequencer states and the address
// source select shared by control and register file
//==================================================
`default_nettype none

package cpuCyclePkg;

  typedef enum logic [3:0] {
    cycReset0,
    cycReset1,
    cycFetch,
    cycOperand,
    cycAbsLo,
    cycAbsHi,
    cycWrite,
    cycVecLo,
    cycVecHi
  } cycleE;

  typedef enum logic [1:0] {
    srcPc,
    srcHold,
    srcVector
  } addrSrcE;

endpackage

`default_nettype wire

/* design/interruptCtrl.sv */
//==================================================
// NMI edge and IRQ level capture; flags stay pending
// until the sequencer reports the vector as taken
//==================================================
`timescale 1ns/1ps
`default_nettype none

module interruptCtrl (
  input  wire  phi0In,
  input  wire  arstN,
  input  wire  nmiL,
  input  wire  irqL,
  input  wire  nmiTaken,
  input  wire  irqTaken,
  output logic nmiPending,
  output logic irqPending
);

  logic nmiPrev;

  always_ff @(posedge phi0In or negedge arstN) begin
    if (!arstN) begin
      nmiPrev    <= 1'b1;
      nmiPending <= 1'b0;
      irqPending <= 1'b0;
    end else begin
      nmiPrev <= nmiL;
      // a new falling edge wins over the clear
      if (nmiPrev && !nmiL) begin
        nmiPending <= 1'b1;
      end else if (nmiTaken) begin
        nmiPending <= 1'b0;
      end
      // cleared for one cycle, re-armed if irqL is still low
      irqPending <= irqTaken ? 1'b0 : (irqPending || !irqL);
    end
  end

  // vector entry only for a request that is actually pending
  assert property (@(posedge phi0In) disable iff (!arstN) nmiTaken |-> nmiPending);
  assert property (@(posedge phi0In) disable iff (!arstN) irqTaken |-> irqPending);

endmodule

`default_nettype wire

/* design/aluUnit.sv */
//==================================================
// combinational 8-bit ALU; carry and overflow pass
// through unchanged except for add-with-carry
//==================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu6502_params.svh"

module aluUnit (
  input  wire cpuIsaPkg::aluOpE     aluOp,
  input  wire  [`CPU_DATA_W-1:0]    opA,
  input  wire  [`CPU_DATA_W-1:0]    opB,
  input  wire                       carryIn,
  input  wire                       overflowIn,
  output logic [`CPU_DATA_W-1:0]    result,
  output logic                      carryOut,
  output logic                      overflow
);

  logic [`CPU_DATA_W:0] sum;

  always_comb begin
    sum      = {1'b0, opA} + {1'b0, opB} + {{`CPU_DATA_W{1'b0}}, carryIn};
    result   = opB;
    carryOut = carryIn;
    overflow = overflowIn;
    case (aluOp)
      cpuIsaPkg::aluAdc: begin
        result   = sum[`CPU_DATA_W-1:0];
        carryOut = sum[`CPU_DATA_W];
        // same operand signs but a different result sign
        overflow = (opA[`CPU_DATA_W-1] == opB[`CPU_DATA_W-1]) &&
                   (sum[`CPU_DATA_W-1] != opA[`CPU_DATA_W-1]);
      end
      cpuIsaPkg::aluAnd:  result = opA & opB;
      cpuIsaPkg::aluOra:  result = opA | opB;
      cpuIsaPkg::aluEor:  result = opA ^ opB;
      cpuIsaPkg::aluInc:  result = opA + `CPU_DATA_W'(1);
      default:            result = opB;
    endcase
  end

endmodule

`default_nettype wire

/* design/statusReg.sv */
//==================================================
// processor status flags, loaded from the ALU result
// or by the set and clear strobes of the sequencer
//==================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu6502_params.svh"

module statusReg (
  input  wire                      phi0In,
  input  wire                      arstN,
  input  wire                      rdy,
  input  wire                      flagsFromAlu,
  input  wire  [`CPU_DATA_W-1:0]   aluResult,
  input  wire                      carryOut,
  input  wire                      overflow,
  input  wire                      setC,
  input  wire                      clrC,
  input  wire                      setI,
  input  wire                      clrI,
  output logic [`CPU_DATA_W-1:0]   statusByte
);

  logic flgC;
  logic flgZ;
  logic flgI;
  logic flgV;
  logic flgN;

  always_ff @(posedge phi0In or negedge arstN) begin
    if (!arstN) begin
      flgC <= 1'b0;
      flgZ <= 1'b0;
      flgI <= 1'b1;
      flgV <= 1'b0;
      flgN <= 1'b0;
    end else if (rdy) begin
      if (flagsFromAlu) begin
        flgN <= aluResult[`CPU_DATA_W-1];
        flgZ <= (aluResult == '0);
        flgC <= carryOut;
        flgV <= overflow;
      end
      if (setC) begin
        flgC <= 1'b1;
      end else if (clrC) begin
        flgC <= 1'b0;
      end
      if (setI) begin
        flgI <= 1'b1;
      end else if (clrI) begin
        flgI <= 1'b0;
      end
    end
  end

  always_comb begin
    // unused bit 5 reads as one, B and D as zero
    statusByte = `CPU_DATA_W'(8'h20);
    statusByte[cpuIsaPkg::flagC] = flgC;
    statusByte[cpuIsaPkg::flagZ] = flgZ;
    statusByte[cpuIsaPkg::flagI] = flgI;
    statusByte[cpuIsaPkg::flagV] = flgV;
    statusByte[cpuIsaPkg::flagN] = flgN;
  end

endmodule

`default_nettype wire

/* design/regFile.sv */
//==================================================
// A, X, Y, program counter and address hold register
// with the address and store data multiplexers
//==================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu6502_params.svh"

module regFile (
  input  wire                        phi0In,
  input  wire                        arstN,
  input  wire                        rdy,
  input  wire  [`CPU_DATA_W-1:0]     dataIn,
  input  wire  [`CPU_DATA_W-1:0]     aluResult,
  input  wire                        loadA,
  input  wire                        loadX,
  input  wire                        loadY,
  input  wire                        pcInc,
  input  wire                        pcLoadHold,
  input  wire                        holdLoLoad,
  input  wire                        holdHiLoad,
  input  wire cpuCyclePkg::addrSrcE  addrSrc,
  input  wire  [`CPU_ADDR_W-1:0]     vecAddr,
  input  wire  [1:0]                 storeSel,
  output logic [`CPU_DATA_W-1:0]     regA,
  output logic [`CPU_DATA_W-1:0]     regX,
  output logic [`CPU_ADDR_W-1:0]     addrOut,
  output logic [`CPU_DATA_W-1:0]     storeData
);

  logic [`CPU_DATA_W-1:0] regY;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_ADDR_W-1:0] holdReg;

  // pc is overwritten from the reset vector before first use
  always_ff @(posedge phi0In or negedge arstN) begin
    if (!arstN) begin
      pc <= '0;
    end else if (rdy) begin
      // high byte arrives on the bus, low byte was held
      if (pcLoadHold) begin
        pc <= {dataIn, holdReg[`CPU_DATA_W-1:0]};
      end else if (pcInc) begin
        pc <= pc + `CPU_ADDR_W'(1);
      end
    end
  end

  always_ff @(posedge phi0In) begin
    if (rdy) begin
      if (loadA) begin
        regA <= aluResult;
      end
      if (loadX) begin
        regX <= aluResult;
      end
      if (loadY) begin
        regY <= aluResult;
      end
      if (holdLoLoad) begin
        holdReg[`CPU_DATA_W-1:0] <= dataIn;
      end
      if (holdHiLoad) begin
        holdReg[`CPU_ADDR_W-1:`CPU_DATA_W] <= dataIn;
      end
    end
  end

  always_comb begin
    case (addrSrc)
      cpuCyclePkg::srcHold:   addrOut = holdReg;
      cpuCyclePkg::srcVector: addrOut = vecAddr;
      default:                addrOut = pc;
    endcase
  end

  always_comb begin
    case (storeSel)
      2'd1:    storeData = regX;
      2'd2:    storeData = regY;
      default: storeData = regA;
    endcase
  end

  // sequencer never asks for both pc updates at once
  assert property (@(posedge phi0In) disable iff (!arstN) !(pcInc && pcLoadHold));

endmodule

`default_nettype wire

/* design/controlFsm.sv */
//==================================================
// opcode decode and bus cycle sequencing, including
// reset and interrupt vector entry and rdy stalls
//==================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu6502_params.svh"

module controlFsm (
  input  wire                        phi0In,
  input  wire                        arstN,
  input  wire                        rdy,
  input  wire  [`CPU_DATA_W-1:0]     dataIn,
  input  wire  [`CPU_DATA_W-1:0]     statusByte,
  input  wire                        nmiPending,
  input  wire                        irqPending,
  output logic                       sync,
  output logic                       rw,
  output cpuIsaPkg::aluOpE           aluOp,
  output logic                       opAFromX,
  output logic                       opBFromA,
  output logic                       loadA,
  output logic                       loadX,
  output logic                       loadY,
  output logic                       pcInc,
  output logic                       pcLoadHold,
  output logic                       holdLoLoad,
  output logic                       holdHiLoad,
  output cpuCyclePkg::addrSrcE       addrSrc,
  output logic [`CPU_ADDR_W-1:0]     vecAddr,
  output logic [1:0]                 storeSel,
  output logic                       flagsFromAlu,
  output logic                       setC,
  output logic                       clrC,
  output logic                       setI,
  output logic                       clrI,
  output logic                       nmiTaken,
  output logic                       irqTaken
);

  cpuCyclePkg::cycleE     state;
  cpuCyclePkg::cycleE     nextState;
  cpuCyclePkg::cycleE     endState;
  cpuIsaPkg::opcodeE      opcode;
  logic                   isNmi;
  logic                   irqTake;
  logic [`CPU_ADDR_W-1:0] vecBase;

  // interrupts are checked once an instruction completes
  assign irqTake  = irqPending && !statusByte[cpuIsaPkg::flagI];
  assign endState = (nmiPending || irqTake) ? cpuCyclePkg::cycVecLo : cpuCyclePkg::cycFetch;

  always_ff @(posedge phi0In or negedge arstN) begin
    if (!arstN) begin
      state  <= cpuCyclePkg::cycReset0;
      opcode <= cpuIsaPkg::opNop;
      isNmi  <= 1'b0;
    end else if (rdy || state == cpuCyclePkg::cycWrite) begin
      state <= nextState;
      if (state == cpuCyclePkg::cycFetch) begin
        opcode <= cpuIsaPkg::opcodeE'(dataIn);
      end
      if (nextState == cpuCyclePkg::cycVecLo) begin
        isNmi <= nmiPending;
      end
    end
  end

  always_comb begin
    case (opcode)
      cpuIsaPkg::opAdcImm: aluOp = cpuIsaPkg::aluAdc;
      cpuIsaPkg::opAndImm: aluOp = cpuIsaPkg::aluAnd;
      cpuIsaPkg::opOraImm: aluOp = cpuIsaPkg::aluOra;
      cpuIsaPkg::opEorImm: aluOp = cpuIsaPkg::aluEor;
      cpuIsaPkg::opInx:    aluOp = cpuIsaPkg::aluInc;
      default:             aluOp = cpuIsaPkg::aluPass;
    endcase
  end

  always_comb begin
    if (state == cpuCyclePkg::cycReset0 || state == cpuCyclePkg::cycReset1) begin
      vecBase = `CPU_RESET_VEC;
    end else if (isNmi) begin
      vecBase = `CPU_NMI_VEC;
    end else begin
      vecBase = `CPU_IRQ_VEC;
    end
    if (state == cpuCyclePkg::cycReset1 || state == cpuCyclePkg::cycVecHi) begin
      vecAddr = vecBase + `CPU_ADDR_W'(1);
    end else begin
      vecAddr = vecBase;
    end
  end

  always_comb begin
    nextState    = state;
    sync         = 1'b0;
    rw           = 1'b1;
    opAFromX     = 1'b0;
    opBFromA     = 1'b0;
    loadA        = 1'b0;
    loadX        = 1'b0;
    // no Y instructions in this subset
    loadY        = 1'b0;
    pcInc        = 1'b0;
    pcLoadHold   = 1'b0;
    holdLoLoad   = 1'b0;
    holdHiLoad   = 1'b0;
    addrSrc      = cpuCyclePkg::srcPc;
    storeSel     = (opcode == cpuIsaPkg::opStxAbs) ? 2'd1 : 2'd0;
    flagsFromAlu = 1'b0;
    setC         = 1'b0;
    clrC         = 1'b0;
    setI         = 1'b0;
    clrI         = 1'b0;
    nmiTaken     = 1'b0;
    irqTaken     = 1'b0;
    case (state)
      cpuCyclePkg::cycReset0: begin
        addrSrc    = cpuCyclePkg::srcVector;
        holdLoLoad = 1'b1;
        nextState  = cpuCyclePkg::cycReset1;
      end
      cpuCyclePkg::cycReset1: begin
        addrSrc    = cpuCyclePkg::srcVector;
        pcLoadHold = 1'b1;
        nextState  = cpuCyclePkg::cycFetch;
      end
      cpuCyclePkg::cycFetch: begin
        sync  = 1'b1;
        pcInc = 1'b1;
        if (dataIn == cpuIsaPkg::opStaAbs || dataIn == cpuIsaPkg::opStxAbs ||
            dataIn == cpuIsaPkg::opJmpAbs) begin
          nextState = cpuCyclePkg::cycAbsLo;
        end else begin
          nextState = cpuCyclePkg::cycOperand;
        end
      end
      cpuCyclePkg::cycOperand: begin
        // implied ops re-read the next opcode byte without consuming it
        nextState = endState;
        case (opcode)
          cpuIsaPkg::opLdaImm, cpuIsaPkg::opAdcImm, cpuIsaPkg::opAndImm,
          cpuIsaPkg::opOraImm, cpuIsaPkg::opEorImm: begin
            pcInc        = 1'b1;
            loadA        = 1'b1;
            flagsFromAlu = 1'b1;
          end
          cpuIsaPkg::opLdxImm: begin
            pcInc        = 1'b1;
            loadX        = 1'b1;
            flagsFromAlu = 1'b1;
          end
          cpuIsaPkg::opTax: begin
            opBFromA     = 1'b1;
            loadX        = 1'b1;
            flagsFromAlu = 1'b1;
          end
          cpuIsaPkg::opInx: begin
            opAFromX     = 1'b1;
            loadX        = 1'b1;
            flagsFromAlu = 1'b1;
          end
          cpuIsaPkg::opClc: clrC = 1'b1;
          cpuIsaPkg::opSec: setC = 1'b1;
          cpuIsaPkg::opCli: clrI = 1'b1;
          cpuIsaPkg::opSei: setI = 1'b1;
          default: ;
        endcase
      end
      cpuCyclePkg::cycAbsLo: begin
        pcInc      = 1'b1;
        holdLoLoad = 1'b1;
        nextState  = cpuCyclePkg::cycAbsHi;
      end
      cpuCyclePkg::cycAbsHi: begin
        if (opcode == cpuIsaPkg::opJmpAbs) begin
          pcLoadHold = 1'b1;
          nextState  = endState;
        end else begin
          pcInc      = 1'b1;
          holdHiLoad = 1'b1;
          nextState  = cpuCyclePkg::cycWrite;
        end
      end
      cpuCyclePkg::cycWrite: begin
        addrSrc   = cpuCyclePkg::srcHold;
        rw        = 1'b0;
        nextState = endState;
      end
      cpuCyclePkg::cycVecLo: begin
        addrSrc    = cpuCyclePkg::srcVector;
        holdLoLoad = 1'b1;
        setI       = 1'b1;
        // one pulse, on the cycle that completes
        nmiTaken   = rdy && isNmi;
        irqTaken   = rdy && !isNmi;
        nextState  = cpuCyclePkg::cycVecHi;
      end
      cpuCyclePkg::cycVecHi: begin
        addrSrc    = cpuCyclePkg::srcVector;
        pcLoadHold = 1'b1;
        nextState  = cpuCyclePkg::cycFetch;
      end
      default: nextState = cpuCyclePkg::cycReset0;
    endcase
  end

  // an opcode fetch must see a driven data bus
  assert property (@(posedge phi0In) disable iff (!arstN)
    (state == cpuCyclePkg::cycFetch && rdy) |-> !$isunknown(dataIn));
  // vector entry leaves further IRQs masked
  assert property (@(posedge phi0In) disable iff (!arstN)
    (setI && rdy) |=> statusByte[cpuIsaPkg::flagI]);

endmodule

`default_nettype wire

/* design/cpu6502Top.sv */
//==================================================
// CPU core top level with the external pin set;
// instantiate this block in a system or testbench
//==================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu6502_params.svh"

module cpu6502Top (
  input  wire                       phi0In,
  input  wire                       arstN,
  input  wire                       rdy,
  input  wire                       irqL,
  input  wire                       nmiL,
  inout  wire  [`CPU_DATA_W-1:0]    extDb,
  output logic [`CPU_ADDR_W-1:0]    extAb,
  output logic                      rw,
  output logic                      sync,
  output logic                      phi1Out,
  output logic                      phi2Out
);

  logic [`CPU_DATA_W-1:0] dataIn;
  logic [`CPU_DATA_W-1:0] storeData;
  logic [`CPU_DATA_W-1:0] regA;
  logic [`CPU_DATA_W-1:0] regX;
  logic [`CPU_DATA_W-1:0] opA;
  logic [`CPU_DATA_W-1:0] opB;
  logic [`CPU_DATA_W-1:0] aluResult;
  logic [`CPU_DATA_W-1:0] statusByte;
  logic [`CPU_ADDR_W-1:0] vecAddr;
  logic [1:0]             storeSel;
  logic                   carryOut;
  logic                   overflow;
  logic                   nmiPending;
  logic                   irqPending;
  logic                   nmiTaken;
  logic                   irqTaken;
  logic                   opAFromX;
  logic                   opBFromA;
  logic                   loadA;
  logic                   loadX;
  logic                   loadY;
  logic                   pcInc;
  logic                   pcLoadHold;
  logic                   holdLoLoad;
  logic                   holdHiLoad;
  logic                   flagsFromAlu;
  logic                   setC;
  logic                   clrC;
  logic                   setI;
  logic                   clrI;
  cpuIsaPkg::aluOpE       aluOp;
  cpuCyclePkg::addrSrcE   addrSrc;

  // two-phase outputs kept for pin compatibility
  assign phi1Out = ~phi0In;
  assign phi2Out = phi0In;

  // data bus driven for the whole write cycle only
  assign extDb  = rw ? {`CPU_DATA_W{1'bz}} : storeData;
  assign dataIn = extDb;

  assign opA = opAFromX ? regX : regA;
  assign opB = opBFromA ? regA : dataIn;

  interruptCtrl intCtrlI (.*);

  aluUnit aluI (
    .*,
    .carryIn    (statusByte[cpuIsaPkg::flagC]),
    .overflowIn (statusByte[cpuIsaPkg::flagV]),
    .result     (aluResult)
  );

  statusReg statusI (.*);

  regFile regsI (
    .*,
    .addrOut (extAb)
  );

  controlFsm fsmI (.*);

endmodule

`default_nettype wire

/* dv/cpu6502Tb.sv */
//==================================================
// testbench for the CPU core; runs each program case
// from reset and checks the first bus write it makes
//==================================================
`timescale 1ns/1ps
`default_nettype none
`include "cpu6502_params.svh"

module cpu6502Tb;

  localparam int clkPeriod  = 8;
  localparam int numCases   = 9;
  localparam int caseCycles = 60;

  // interrupt event kinds in the case table
  localparam int evNone = 0;
  localparam int evIrq  = 1;
  localparam int evNmi  = 2;

  logic phi0In = 1'b0;
  logic arstN  = 1'b0;
  logic rdy    = 1'b1;
  logic irqL   = 1'b1;
  logic nmiL   = 1'b1;

  wire  [`CPU_DATA_W-1:0] extDb;
  wire  [`CPU_ADDR_W-1:0] extAb;
  wire                    rw;
  wire                    sync;
  wire                    phi1Out;
  wire                    phi2Out;

  logic [`CPU_DATA_W-1:0] mem [0:65535];
  logic [`CPU_DATA_W-1:0] busData   = 8'h00;
  logic [15:0]            lfsrState = 16'd43898;
  int                     cycleCount = 0;
  int                     curCase    = 0;
  int                     writeCount = 0;
  logic [`CPU_ADDR_W-1:0] wrAddr;
  logic [`CPU_DATA_W-1:0] wrData;
  logic [`CPU_ADDR_W-1:0] fetchAddr;
  logic                   fetchSeen = 1'b0;

  // case table
  string       caseName    [numCases];
  logic [127:0] caseProg   [numCases];
  logic [15:0] caseReset   [numCases];
  logic [15:0] caseIrqVec  [numCases];
  logic [15:0] caseNmiVec  [numCases];
  logic [15:0] caseAuxAddr [numCases];
  logic [63:0] caseAux     [numCases];
  logic        caseStall   [numCases];
  int          caseEvKind  [numCases];
  int          caseEvCycle [numCases];
  logic [15:0] caseExpAddr [numCases];
  logic [7:0]  caseExpData [numCases];

  cpu6502Top dut_i (
    .phi0In  (phi0In),
    .arstN   (arstN),
    .rdy     (rdy),
    .irqL    (irqL),
    .nmiL    (nmiL),
    .extDb   (extDb),
    .extAb   (extAb),
    .rw      (rw),
    .sync    (sync),
    .phi1Out (phi1Out),
    .phi2Out (phi2Out)
  );

  always #(clkPeriod / 2) phi0In = ~phi0In;

  // memory answers only while the CPU reads
  assign extDb = rw ? busData : {`CPU_DATA_W{1'bz}};

  function automatic logic [15:0] galoisStep(input logic [15:0] s);
    galoisStep = {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // 6502 binary add, carry in bit 8
  function automatic logic [8:0] addWithCarry(input logic [7:0] a, input logic [7:0] b,
                                              input logic cin);
    addWithCarry = {1'b0, a} + {1'b0, b} + {8'h00, cin};
  endfunction

  // memory data, rdy and interrupt pins change on the falling edge
  always @(negedge phi0In) begin
    busData <= mem[extAb];
    if (!arstN) begin
      cycleCount <= 0;
      rdy        <= 1'b1;
      irqL       <= 1'b1;
      nmiL       <= 1'b1;
    end else begin
      cycleCount <= cycleCount + 1;
      if (caseStall[curCase]) begin
        rdy       <= lfsrState[0];
        lfsrState <= galoisStep(lfsrState);
      end else begin
        rdy <= 1'b1;
      end
      if (caseEvKind[curCase] == evIrq && cycleCount >= caseEvCycle[curCase]) begin
        irqL <= 1'b0;
      end
      if (caseEvKind[curCase] == evNmi && cycleCount >= caseEvCycle[curCase]) begin
        nmiL <= 1'b0;
      end
    end
  end

  // record the first opcode fetch and each write cycle as it completes
  always @(posedge phi0In) begin
    if (!arstN) begin
      fetchSeen <= 1'b0;
      fetchAddr <= 'x;
    end else begin
      if (sync && !fetchSeen) begin
        fetchAddr <= extAb;
        fetchSeen <= 1'b1;
      end
      if (!rw) begin
        wrAddr     <= extAb;
        wrData     <= extDb;
        writeCount <= writeCount + 1;
      end
    end
  end

  task automatic checkEqual(input string testName, input string field,
                            input logic [15:0] expected, input logic [15:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s expected %h actual %h", testName, field, expected, actual);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // phi2Out follows phi0In, phi1Out is its inverse
  task automatic checkClockPhases();
    @(posedge phi0In);
    #(clkPeriod / 4);
    checkEqual("clock_phases", "high", 16'h0001, {14'h0000, phi1Out, phi2Out});
    #(clkPeriod / 2);
    checkEqual("clock_phases", "low", 16'h0002, {14'h0000, phi1Out, phi2Out});
  endtask

  task automatic addCase(input int idx, input string name, input logic [127:0] prog,
                         input logic [15:0] resetVec, input logic [15:0] irqVec,
                         input logic [15:0] nmiVec, input logic [15:0] auxAddr,
                         input logic [63:0] aux, input logic stall, input int evKind,
                         input int evCycle, input logic [15:0] expAddr,
                         input logic [7:0] expData);
    caseName[idx]    = name;
    caseProg[idx]    = prog;
    caseReset[idx]   = resetVec;
    caseIrqVec[idx]  = irqVec;
    caseNmiVec[idx]  = nmiVec;
    caseAuxAddr[idx] = auxAddr;
    caseAux[idx]     = aux;
    caseStall[idx]   = stall;
    caseEvKind[idx]  = evKind;
    caseEvCycle[idx] = evCycle;
    caseExpAddr[idx] = expAddr;
    caseExpData[idx] = expData;
  endtask

  task automatic buildTable();
    logic [8:0] sum;
    logic [7:0] aluExp;
    // SEC, LDA #7F, ADC #01, then the logic ops
    sum    = addWithCarry(8'h7F, 8'h01, 1'b1);
    aluExp = ((sum[7:0] & 8'hF0) | 8'h03) ^ 8'hFF;
    addCase(0, "reset_imm_store", 128'hA9_5A_8D_00_03_EA_EA_EA_EA_EA_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hEA_EA_EA_EA_EA_EA_EA_EA,
            1'b0, evNone, 0, 16'h0300, 8'h5A);
    addCase(1, "alu_carry", 128'h38_A9_7F_69_01_29_F0_09_03_49_FF_8D_00_03_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hEA_EA_EA_EA_EA_EA_EA_EA,
            1'b0, evNone, 0, 16'h0300, aluExp);
    addCase(2, "x_path", 128'hA9_10_AA_E8_8E_10_03_EA_EA_EA_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hEA_EA_EA_EA_EA_EA_EA_EA,
            1'b0, evNone, 0, 16'h0310, 8'h10 + 8'h01);
    addCase(3, "jmp_skip", 128'hA9_C3_4C_50_02_A9_EE_8D_00_03_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0250, 64'h8D_30_03_EA_EA_EA_EA_EA,
            1'b0, evNone, 0, 16'h0330, 8'hC3);
    addCase(4, "rdy_imm_store", 128'hA9_5A_8D_00_03_EA_EA_EA_EA_EA_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hEA_EA_EA_EA_EA_EA_EA_EA,
            1'b1, evNone, 0, 16'h0300, 8'h5A);
    addCase(5, "rdy_x_path", 128'hA9_10_AA_E8_8E_10_03_EA_EA_EA_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hEA_EA_EA_EA_EA_EA_EA_EA,
            1'b1, evNone, 0, 16'h0310, 8'h10 + 8'h01);
    // irq handler stores A1, nmi handler stores B2
    addCase(6, "irq_masked", 128'hA9_5A_8D_00_03_EA_EA_EA_EA_EA_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hA9_A1_8D_40_03_EA_EA_EA,
            1'b0, evIrq, 0, 16'h0300, 8'h5A);
    addCase(7, "irq_taken", 128'h58_EA_EA_A9_5A_8D_00_03_EA_EA_EA_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h0280, 64'hA9_A1_8D_40_03_EA_EA_EA,
            1'b0, evIrq, 0, 16'h0340, 8'hA1);
    addCase(8, "nmi_edge", 128'hEA_EA_EA_EA_EA_EA_A9_5A_8D_00_03_EA_EA_EA_EA_EA,
            16'h0200, 16'h0280, 16'h02C0, 16'h02C0, 64'hA9_B2_8D_50_03_EA_EA_EA,
            1'b0, evNmi, 4, 16'h0350, 8'hB2);
  endtask

  task automatic loadMemory(input int idx);
    logic [15:0] addr;
    for (int a = 0; a < 65536; a++) begin
      addr      = 16'(a);
      mem[addr] = addr[7:0] ^ addr[15:8] ^ 8'hC5;
    end
    for (int i = 0; i < 16; i++) begin
      mem[16'h0200 + 16'(i)] = caseProg[idx][127 - 8 * i -: 8];
    end
    for (int i = 0; i < 8; i++) begin
      mem[caseAuxAddr[idx] + 16'(i)] = caseAux[idx][63 - 8 * i -: 8];
    end
    mem[`CPU_RESET_VEC]     = caseReset[idx][7:0];
    mem[`CPU_RESET_VEC + 1] = caseReset[idx][15:8];
    mem[`CPU_NMI_VEC]       = caseNmiVec[idx][7:0];
    mem[`CPU_NMI_VEC + 1]   = caseNmiVec[idx][15:8];
    mem[`CPU_IRQ_VEC]       = caseIrqVec[idx][7:0];
    mem[`CPU_IRQ_VEC + 1]   = caseIrqVec[idx][15:8];
  endtask

  task automatic runCase(input int idx);
    int startCount;
    @(negedge phi0In);
    arstN <= 1'b0;
    // reconfigure away from the falling edge
    @(posedge phi0In);
    curCase = idx;
    loadMemory(idx);
    repeat (4) @(negedge phi0In);
    startCount = writeCount;
    arstN <= 1'b1;
    wait (writeCount != startCount);
    checkEqual(caseName[idx], "address", caseExpAddr[idx], wrAddr);
    checkEqual(caseName[idx], "data", {8'h00, caseExpData[idx]}, {8'h00, wrData});
    // first opcode fetch comes from the reset vector with sync high
    checkEqual(caseName[idx], "first fetch", caseReset[idx], fetchAddr);
  endtask

  initial begin
    buildTable();
    checkClockPhases();
    for (int i = 0; i < numCases; i++) begin
      runCase(i);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // whole-run limit scaled by the number of cases
  initial begin
    #(caseCycles * numCases * clkPeriod);
    $display("watchdog expired before every case produced its first write");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* cpu6502.f */
+incdir+design
design/cpuIsaPkg.sv
design/cpuCyclePkg.sv
design/interruptCtrl.sv
design/aluUnit.sv
design/statusReg.sv
design/regFile.sv
design/controlFsm.sv
design/cpu6502Top.sv
dv/cpu6502Tb.sv

/* Bender.yml */
package:
  name: cpu6502

export_include_dirs:
  - design

sources:
  - files:
      - design/cpuIsaPkg.sv
      - design/cpuCyclePkg.sv
      - design/interruptCtrl.sv
      - design/aluUnit.sv
      - design/statusReg.sv
      - design/regFile.sv
      - design/controlFsm.sv
      - design/cpu6502Top.sv
  - target: simulation
    files:
      - dv/cpu6502Tb.sv
